// ==== compile.f ====
design/maze_pkg.sv
design/level_rom.sv
design/tile_map.sv
design/move_probe.sv
design/tile_painter.sv
design/game_fsm.sv
design/maze_game_top.sv
sim/tb_clock_gen.sv
sim/maze_game_tb.sv

// ==== Bender.yml ====
package:
  name: maze_game

sources:
  - design/maze_pkg.sv
  - design/level_rom.sv
  - design/tile_map.sv
  - design/move_probe.sv
  - design/tile_painter.sv
  - design/game_fsm.sv
  - design/maze_game_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/maze_game_tb.sv

// ==== sim/maze_game_tb.sv ====
module maze_game_tb;
	import maze_pkg::*;

	localparam int RESET_CYCLES = 5;
	// pixel_tick high on TICK_NUM of every TICK_DEN clocks on average
	localparam int TICK_NUM = 3;
	localparam int TICK_DEN = 4;
	localparam int PAINT_COUNT = 6;
	localparam int PAINT_CYCLES = CELL_COUNT * TICK_DEN / TICK_NUM;
	// Doubling leaves room for the four loads
	localparam int WATCHDOG_CYCLES = 2 * PAINT_COUNT * PAINT_CYCLES;
	localparam logic [PX_X_W-1:0] START_X = 8'd5;
	localparam logic [PX_Y_W-1:0] START_Y = 7'd5;

	logic clock;
	logic reset = 1'b1;
	logic pixel_tick = 1'b0;
	logic [PX_X_W-1:0] player_x = START_X;
	logic [PX_Y_W-1:0] player_y = START_Y;
	logic [DIR_W-1:0] direction = '0;
	logic [COLOUR_W-1:0] colour;
	logic [PX_X_W-1:0] x_out;
	logic [PX_Y_W-1:0] y_out;
	logic stop;
	logic player_reset;

	integer seed = 63171;
	int fail_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int exp_level = 0;
	bit key_taken = 1'b0;

	// Reference scan position and probe target
	bit painting;
	int scan_col;
	int scan_row;
	int paints_done;
	logic scan_last;
	logic [COLOUR_W-1:0] exp_colour;
	logic [PX_X_W-1:0] exp_x;
	logic [PX_Y_W-1:0] exp_y;
	int target_x;
	int target_y;
	logic exp_moving;
	logic [COLOUR_W-1:0] target_tile;
	logic exp_hit;
	logic exp_restart;

	tb_clock_gen u_clock (.clock(clock));

	maze_game_top u_dut (
		.clock(clock),
		.reset(reset),
		.pixel_tick(pixel_tick),
		.player_x(player_x),
		.player_y(player_y),
		.direction(direction),
		.colour(colour),
		.x_out(x_out),
		.y_out(y_out),
		.stop(stop),
		.player_reset(player_reset)
	);

	// Map contents per level with the key update applied or not
	function automatic logic [COLOUR_W-1:0] model_tile(input int lvl, input bit key_gone,
		input int col, input int row);
		int key_col;
		int goal_col;
		int goal_row;
		key_col = (lvl == 0) ? 3 : 28;
		goal_col = (lvl == 0) ? 25 : 2;
		goal_row = (lvl == 0) ? 3 : 2;
		if (row == 0 || row == MAP_H - 1 || col == 0 || col == MAP_W - 1)
			return TILE_WALL;
		if (col == key_col && row == 20)
			return key_gone ? TILE_BLANK : TILE_KEY;
		if (col == goal_col && row == goal_row)
			return key_gone ? TILE_GOAL : TILE_BLANK;
		if (lvl == 0)
		begin
			if (col == 10 && row <= 20)
				return TILE_WALL;
			if (col == 5 && row == 5)
				return TILE_TRAP;
		end
		else
		begin
			if (row == 12 && col <= 28)
				return TILE_WALL;
			if (col == 20 && row == 5)
				return TILE_TRAP;
		end
		return TILE_BLANK;
	endfunction

	task automatic show_mismatch(input string name, input int expected, input int actual);
		$display("CHECK FAILED at time %0t: %s expected %0h, actual %0h",
			$time, name, expected, actual);
		fail_count++;
	endtask

	task automatic note_violation(input string what);
		$display("Error at time %0t: %s", $time, what);
		fail_count++;
	endtask

	task automatic close_test(input string name, input int fails_before);
		if (fail_count == fails_before)
		begin
			tests_passed++;
			$display("Test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, fail_count - fails_before);
		end
	endtask

	// Puts the player next to a tile and pushes until the DUT freezes it
	task automatic move_until_stop(input logic [PX_X_W-1:0] x, input logic [PX_Y_W-1:0] y,
		input logic [DIR_W-1:0] dir);
		@(posedge clock);
		player_x <= x;
		player_y <= y;
		direction <= dir;
		@(negedge clock);
		while (!stop)
			@(negedge clock);
	endtask

	task automatic release_player(input logic [PX_X_W-1:0] x, input logic [PX_Y_W-1:0] y);
		@(posedge clock);
		player_x <= x;
		player_y <= y;
		direction <= '0;
	endtask

	task automatic wait_for_play(input int paints);
		while (paints_done < paints)
			@(negedge clock);
		while (stop || player_reset)
			@(negedge clock);
	endtask

	always @(posedge clock)
		pixel_tick <= ($unsigned($random(seed)) % TICK_DEN) < TICK_NUM;

	// Raster order with x fastest and one cell per tick
	always @(posedge clock)
	begin
		if (reset)
		begin
			painting <= 1'b0;
			scan_col <= 0;
			scan_row <= 0;
			paints_done <= 0;
		end
		else if (u_dut.draw_start)
		begin
			painting <= 1'b1;
			scan_col <= 0;
			scan_row <= 0;
		end
		else if (painting && pixel_tick)
		begin
			if (scan_last)
			begin
				painting <= 1'b0;
				paints_done <= paints_done + 1;
			end
			else if (scan_col == MAP_W - 1)
			begin
				scan_col <= 0;
				scan_row <= scan_row + 1;
			end
			else
				scan_col <= scan_col + 1;
		end
	end

	always_comb
	begin
		scan_last = (scan_col == MAP_W - 1) && (scan_row == MAP_H - 1);
		exp_colour = model_tile(exp_level, key_taken, scan_col, scan_row);
		exp_x = PX_X_W'(scan_col * TILE_PX);
		exp_y = PX_Y_W'(scan_row * TILE_PX);
	end

	always_comb
	begin
		exp_moving = 1'b1;
		target_x = player_x;
		target_y = player_y;
		case (direction)
			DIR_UP: target_y = player_y - 1;
			DIR_DOWN: target_y = player_y + TILE_PX;
			DIR_LEFT: target_x = player_x - 1;
			DIR_RIGHT: target_x = player_x + TILE_PX;
			default: exp_moving = 1'b0;
		endcase
		target_tile = model_tile(exp_level, key_taken, target_x / 5, target_y / 5);
		exp_hit = exp_moving && (target_tile != TILE_BLANK);
		exp_restart = exp_moving && (target_tile == TILE_TRAP || target_tile == TILE_GOAL);
	end

	a_reset_state: assert property (@(posedge clock)
		$fell(reset) |-> player_reset && !stop && !u_dut.playing)
		else note_violation("outputs after reset are not those of the load state");

	a_paint_colour: assert property (@(posedge clock) disable iff (reset)
		painting && pixel_tick |-> colour == exp_colour)
		else show_mismatch("colour", $sampled(exp_colour), $sampled(colour));

	a_paint_x: assert property (@(posedge clock) disable iff (reset)
		painting && pixel_tick |-> x_out == exp_x)
		else show_mismatch("x_out", $sampled(exp_x), $sampled(x_out));

	a_paint_y: assert property (@(posedge clock) disable iff (reset)
		painting && pixel_tick |-> y_out == exp_y)
		else show_mismatch("y_out", $sampled(exp_y), $sampled(y_out));

	a_paint_end: assert property (@(posedge clock) disable iff (reset)
		painting && pixel_tick |-> u_dut.draw_done == scan_last)
		else show_mismatch("draw_done", $sampled(scan_last), $sampled(u_dut.draw_done));

	a_hand_over: assert property (@(posedge clock) disable iff (reset)
		u_dut.draw_done |=> !player_reset && u_dut.playing)
		else note_violation("player not handed the screen after the paint finished");

	a_play_colour: assert property (@(posedge clock) disable iff (reset)
		u_dut.playing |-> colour == COLOUR_PLAYER)
		else show_mismatch("colour", COLOUR_PLAYER, $sampled(colour));

	a_play_x: assert property (@(posedge clock) disable iff (reset)
		u_dut.playing |-> x_out == player_x)
		else show_mismatch("x_out", $sampled(player_x), $sampled(x_out));

	a_play_y: assert property (@(posedge clock) disable iff (reset)
		u_dut.playing |-> y_out == player_y)
		else show_mismatch("y_out", $sampled(player_y), $sampled(y_out));

	a_stop_on_hit: assert property (@(posedge clock) disable iff (reset)
		u_dut.playing && exp_hit |=> stop)
		else show_mismatch("stop", 1, $sampled(stop));

	a_stop_clear: assert property (@(posedge clock) disable iff (reset)
		u_dut.playing && !exp_moving |=> !stop)
		else show_mismatch("stop", 0, $sampled(stop));

	a_restart: assert property (@(posedge clock) disable iff (reset)
		u_dut.playing && exp_restart |=> player_reset)
		else show_mismatch("player_reset", 1, $sampled(player_reset));

	a_no_restart: assert property (@(posedge clock) disable iff (reset)
		u_dut.playing && exp_hit && !exp_restart |=> !player_reset)
		else show_mismatch("player_reset", 0, $sampled(player_reset));

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles before the tests finished",
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int mark;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		mark = fail_count;
		wait_for_play(1);
		repeat (4) @(negedge clock);
		close_test("1 level 0 paint after reset", mark);

		// Player in column 9 beside the column 10 wall
		mark = fail_count;
		move_until_stop(8'd45, 7'd15, DIR_RIGHT);
		release_player(8'd45, 7'd15);
		while (stop)
			@(negedge clock);
		close_test("2 wall stops the player", mark);

		mark = fail_count;
		move_until_stop(8'd25, 7'd30, DIR_UP);
		release_player(START_X, START_Y);
		wait_for_play(2);
		close_test("3 trap reloads level 0", mark);

		mark = fail_count;
		move_until_stop(8'd15, 7'd95, DIR_DOWN);
		key_taken = 1'b1;
		release_player(START_X, START_Y);
		wait_for_play(3);
		close_test("4 key reveals the goal", mark);

		mark = fail_count;
		move_until_stop(8'd120, 7'd15, DIR_RIGHT);
		exp_level = (exp_level + 1) % LEVEL_COUNT;
		key_taken = 1'b0;
		release_player(START_X, START_Y);
		wait_for_play(4);
		move_until_stop(8'd140, 7'd95, DIR_DOWN);
		key_taken = 1'b1;
		release_player(START_X, START_Y);
		wait_for_play(5);
		// Level 1 goal at (2,2) entered from the right
		move_until_stop(8'd15, 7'd10, DIR_LEFT);
		exp_level = (exp_level + 1) % LEVEL_COUNT;
		key_taken = 1'b0;
		release_player(START_X, START_Y);
		wait_for_play(6);
		close_test("5 goals advance the level and wrap", mark);

		$display("Tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, fail_count);
		if (fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic clock
);

	localparam int PERIOD = 20;

	initial
	begin
		clock = 1'b0;
		forever
			#(PERIOD / 2) clock = ~clock;
	end

endmodule

// ==== design/maze_game_top.sv ====
module maze_game_top (
	input logic clock,
	input logic reset,
	input logic pixel_tick,
	input logic [maze_pkg::PX_X_W-1:0] player_x,
	input logic [maze_pkg::PX_Y_W-1:0] player_y,
	input logic [maze_pkg::DIR_W-1:0] direction,
	output logic [maze_pkg::COLOUR_W-1:0] colour,
	output logic [maze_pkg::PX_X_W-1:0] x_out,
	output logic [maze_pkg::PX_Y_W-1:0] y_out,
	output logic stop,
	output logic player_reset
);
	import maze_pkg::*;

	logic [LEVEL_W-1:0] level;
	logic load_start;
	logic load_done;
	logic key_take;
	logic draw_start;
	logic draw_done;
	logic playing;
	logic [COL_W-1:0] draw_col;
	logic [ROW_W-1:0] draw_row;
	logic [COLOUR_W-1:0] draw_tile;
	logic [COL_W-1:0] probe_col;
	logic [ROW_W-1:0] probe_row;
	logic [COLOUR_W-1:0] probe_tile;
	logic hit_wall;
	logic hit_trap;
	logic hit_goal;
	logic hit_key;

	game_fsm u_fsm (
		.clock(clock),
		.reset(reset),
		.load_done(load_done),
		.draw_done(draw_done),
		.hit_wall(hit_wall),
		.hit_trap(hit_trap),
		.hit_goal(hit_goal),
		.hit_key(hit_key),
		.level(level),
		.load_start(load_start),
		.key_take(key_take),
		.draw_start(draw_start),
		.playing(playing),
		.stop(stop),
		.player_reset(player_reset)
	);

	tile_map u_map (
		.clock(clock),
		.reset(reset),
		.level(level),
		.load_start(load_start),
		.key_take(key_take),
		.draw_col(draw_col),
		.draw_row(draw_row),
		.probe_col(probe_col),
		.probe_row(probe_row),
		.load_done(load_done),
		.draw_tile(draw_tile),
		.probe_tile(probe_tile)
	);

	move_probe u_probe (
		.player_x(player_x),
		.player_y(player_y),
		.direction(direction),
		.probe_tile(probe_tile),
		.probe_col(probe_col),
		.probe_row(probe_row),
		.hit_wall(hit_wall),
		.hit_trap(hit_trap),
		.hit_goal(hit_goal),
		.hit_key(hit_key)
	);

	tile_painter u_painter (
		.clock(clock),
		.reset(reset),
		.pixel_tick(pixel_tick),
		.draw_start(draw_start),
		.playing(playing),
		.draw_tile(draw_tile),
		.player_x(player_x),
		.player_y(player_y),
		.draw_col(draw_col),
		.draw_row(draw_row),
		.draw_done(draw_done),
		.colour(colour),
		.x_out(x_out),
		.y_out(y_out)
	);

endmodule

// ==== design/game_fsm.sv ====
module game_fsm (
	input logic clock,
	input logic reset,
	input logic load_done,
	input logic draw_done,
	input logic hit_wall,
	input logic hit_trap,
	input logic hit_goal,
	input logic hit_key,
	output logic [maze_pkg::LEVEL_W-1:0] level,
	output logic load_start,
	output logic key_take,
	output logic draw_start,
	output logic playing,
	output logic stop,
	output logic player_reset
);
	import maze_pkg::*;

	logic [STATE_W-1:0] state;
	logic entry;
	logic any_hit;
	logic [LEVEL_W-1:0] next_level;

	assign any_hit = hit_wall | hit_trap | hit_goal | hit_key;
	assign next_level = (level == LEVEL_W'(LEVEL_COUNT - 1)) ? '0 : level + 1'b1;

	// Start strobes fire in the first cycle of their state
	assign load_start = (state == S_LOAD) && entry;
	assign draw_start = (state == S_DRAW) && entry;
	assign key_take = (state == S_KEY);
	assign playing = (state == S_PLAY);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= S_LOAD;
			entry <= 1'b1;
			level <= '0;
			stop <= 1'b0;
			player_reset <= 1'b1;
		end
		else
		begin
			entry <= 1'b0;
			case (state)
				S_LOAD:
				begin
					if (load_done)
					begin
						state <= S_DRAW;
						entry <= 1'b1;
					end
				end
				S_DRAW:
				begin
					if (draw_done)
					begin
						state <= S_PLAY;
						player_reset <= 1'b0;
					end
				end
				S_PLAY:
				begin
					// Any blocked or eventful move freezes the player
					stop <= any_hit;
					if (hit_trap)
					begin
						state <= S_LOAD;
						entry <= 1'b1;
						player_reset <= 1'b1;
					end
					else if (hit_goal)
					begin
						level <= next_level;
						state <= S_LOAD;
						entry <= 1'b1;
						player_reset <= 1'b1;
					end
					else if (hit_key)
						state <= S_KEY;
				end
				S_KEY:
				begin
					// Map update happens this cycle, then repaint
					state <= S_DRAW;
					entry <= 1'b1;
				end
				default:
				begin
					state <= S_LOAD;
					entry <= 1'b1;
				end
			endcase
		end
	end

	a_no_reset_in_play: assert property (@(posedge clock) disable iff (reset)
		playing |-> !player_reset);

endmodule

// ==== design/tile_painter.sv ====
module tile_painter (
	input logic clock,
	input logic reset,
	input logic pixel_tick,
	input logic draw_start,
	input logic playing,
	input logic [maze_pkg::COLOUR_W-1:0] draw_tile,
	input logic [maze_pkg::PX_X_W-1:0] player_x,
	input logic [maze_pkg::PX_Y_W-1:0] player_y,
	output logic [maze_pkg::COL_W-1:0] draw_col,
	output logic [maze_pkg::ROW_W-1:0] draw_row,
	output logic draw_done,
	output logic [maze_pkg::COLOUR_W-1:0] colour,
	output logic [maze_pkg::PX_X_W-1:0] x_out,
	output logic [maze_pkg::PX_Y_W-1:0] y_out
);
	import maze_pkg::*;

	logic scanning;
	logic last_cell;

	assign last_cell = (draw_col == COL_W'(MAP_W - 1)) && (draw_row == ROW_W'(MAP_H - 1));
	assign draw_done = scanning && pixel_tick && last_cell;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			scanning <= 1'b0;
			draw_col <= '0;
			draw_row <= '0;
		end
		else if (draw_start)
		begin
			scanning <= 1'b1;
			draw_col <= '0;
			draw_row <= '0;
		end
		else if (scanning && pixel_tick)
		begin
			if (last_cell)
				scanning <= 1'b0;
			else if (draw_col == COL_W'(MAP_W - 1))
			begin
				draw_col <= '0;
				draw_row <= draw_row + 1'b1;
			end
			else
				draw_col <= draw_col + 1'b1;
		end
	end

	// Player sprite while playing, map tiles otherwise
	assign colour = playing ? COLOUR_PLAYER : draw_tile;
	assign x_out = playing ? player_x : PX_X_W'(draw_col * TILE_PX);
	assign y_out = playing ? player_y : PX_Y_W'(draw_row * TILE_PX);

	a_no_paint_in_play: assert property (@(posedge clock) disable iff (reset)
		playing |-> !draw_done);

endmodule

// ==== design/move_probe.sv ====
module move_probe (
	input logic [maze_pkg::PX_X_W-1:0] player_x,
	input logic [maze_pkg::PX_Y_W-1:0] player_y,
	input logic [maze_pkg::DIR_W-1:0] direction,
	input logic [maze_pkg::COLOUR_W-1:0] probe_tile,
	output logic [maze_pkg::COL_W-1:0] probe_col,
	output logic [maze_pkg::ROW_W-1:0] probe_row,
	output logic hit_wall,
	output logic hit_trap,
	output logic hit_goal,
	output logic hit_key
);
	import maze_pkg::*;

	logic moving;
	logic [PX_X_W:0] target_x;
	logic [PX_Y_W:0] target_y;

	// Pixel just past the player's edge in the requested direction
	always_comb
	begin
		moving = 1'b1;
		target_x = {1'b0, player_x};
		target_y = {1'b0, player_y};
		case (direction)
			DIR_UP: target_y = {1'b0, player_y} - 1'b1;
			DIR_DOWN: target_y = {1'b0, player_y} + (PX_Y_W + 1)'(TILE_PX);
			DIR_LEFT: target_x = {1'b0, player_x} - 1'b1;
			DIR_RIGHT: target_x = {1'b0, player_x} + (PX_X_W + 1)'(TILE_PX);
			default: moving = 1'b0;
		endcase
	end

	assign probe_col = COL_W'(target_x / TILE_PX);
	assign probe_row = ROW_W'(target_y / TILE_PX);

	assign hit_wall = moving && (probe_tile == TILE_WALL);
	assign hit_trap = moving && (probe_tile == TILE_TRAP);
	assign hit_goal = moving && (probe_tile == TILE_GOAL);
	assign hit_key = moving && (probe_tile == TILE_KEY);

endmodule

// ==== design/tile_map.sv ====
module tile_map (
	input logic clock,
	input logic reset,
	input logic [maze_pkg::LEVEL_W-1:0] level,
	input logic load_start,
	input logic key_take,
	input logic [maze_pkg::COL_W-1:0] draw_col,
	input logic [maze_pkg::ROW_W-1:0] draw_row,
	input logic [maze_pkg::COL_W-1:0] probe_col,
	input logic [maze_pkg::ROW_W-1:0] probe_row,
	output logic load_done,
	output logic [maze_pkg::COLOUR_W-1:0] draw_tile,
	output logic [maze_pkg::COLOUR_W-1:0] probe_tile
);
	import maze_pkg::*;

	logic [COLOUR_W-1:0] mem [0:CELL_COUNT-1];

	logic loading;
	logic load_last;
	logic [COL_W-1:0] load_col;
	logic [ROW_W-1:0] load_row;
	logic [COLOUR_W-1:0] rom_tile;
	logic [COL_W-1:0] key_col;
	logic [ROW_W-1:0] key_row;
	logic [COL_W-1:0] goal_col;
	logic [ROW_W-1:0] goal_row;

	level_rom u_rom (
		.level(level),
		.col(load_col),
		.row(load_row),
		.tile(rom_tile),
		.key_col(key_col),
		.key_row(key_row),
		.goal_col(goal_col),
		.goal_row(goal_row)
	);

	assign load_last = loading && (load_col == COL_W'(MAP_W - 1)) &&
		(load_row == ROW_W'(MAP_H - 1));
	assign load_done = load_last;

	// Loader walks the map in raster order, one cell per clock
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			loading <= 1'b0;
			load_col <= '0;
			load_row <= '0;
		end
		else if (load_start)
		begin
			loading <= 1'b1;
			load_col <= '0;
			load_row <= '0;
		end
		else if (loading)
		begin
			if (load_last)
				loading <= 1'b0;
			else if (load_col == COL_W'(MAP_W - 1))
			begin
				load_col <= '0;
				load_row <= load_row + 1'b1;
			end
			else
				load_col <= load_col + 1'b1;
		end
	end

	// Address is {row, col} since a row is exactly 32 cells
	always_ff @(posedge clock)
	begin
		if (loading)
			mem[{load_row, load_col}] <= rom_tile;
		else if (key_take)
		begin
			mem[{key_row, key_col}] <= TILE_BLANK;
			mem[{goal_row, goal_col}] <= TILE_GOAL;
		end
	end

	assign draw_tile = mem[{draw_row, draw_col}];
	assign probe_tile = mem[{probe_row, probe_col}];

	a_no_load_during_key: assert property (@(posedge clock) disable iff (reset)
		!(load_start && key_take));

endmodule

// ==== design/level_rom.sv ====
module level_rom (
	input logic [maze_pkg::LEVEL_W-1:0] level,
	input logic [maze_pkg::COL_W-1:0] col,
	input logic [maze_pkg::ROW_W-1:0] row,
	output logic [maze_pkg::COLOUR_W-1:0] tile,
	output logic [maze_pkg::COL_W-1:0] key_col,
	output logic [maze_pkg::ROW_W-1:0] key_row,
	output logic [maze_pkg::COL_W-1:0] goal_col,
	output logic [maze_pkg::ROW_W-1:0] goal_row
);
	import maze_pkg::*;

	logic border;

	assign border = (row == '0) || (row == ROW_W'(MAP_H - 1)) ||
		(col == '0) || (col == COL_W'(MAP_W - 1));

	// Goal cell stays blank here, it only appears once the key is taken
	always_comb
	begin
		tile = TILE_BLANK;
		if (border)
			tile = TILE_WALL;
		else if (level == '0)
		begin
			if (col == 5'd10 && row >= 5'd1 && row <= 5'd20)
				tile = TILE_WALL;
			else if (col == 5'd5 && row == 5'd5)
				tile = TILE_TRAP;
			else if (col == 5'd3 && row == 5'd20)
				tile = TILE_KEY;
		end
		else
		begin
			if (row == 5'd12 && col >= 5'd1 && col <= 5'd28)
				tile = TILE_WALL;
			else if (col == 5'd20 && row == 5'd5)
				tile = TILE_TRAP;
			else if (col == 5'd28 && row == 5'd20)
				tile = TILE_KEY;
		end
	end

	assign key_col = (level == '0) ? 5'd3 : 5'd28;
	assign key_row = 5'd20;
	assign goal_col = (level == '0) ? 5'd25 : 5'd2;
	assign goal_row = (level == '0) ? 5'd3 : 5'd2;

endmodule

// ==== design/maze_pkg.sv ====
package maze_pkg;

	// Map geometry
	localparam int unsigned TILE_PX = 5;
	localparam int unsigned MAP_W = 32;
	localparam int unsigned MAP_H = 24;
	localparam int unsigned CELL_COUNT = MAP_W * MAP_H;
	localparam int unsigned COL_W = 5;
	localparam int unsigned ROW_W = 5;
	localparam int unsigned PX_X_W = 8;
	localparam int unsigned PX_Y_W = 7;

	// Tile codes double as the painted colour
	localparam int unsigned COLOUR_W = 6;
	localparam logic [COLOUR_W-1:0] TILE_BLANK = 6'b000000;
	localparam logic [COLOUR_W-1:0] TILE_TRAP = 6'b110000;
	localparam logic [COLOUR_W-1:0] TILE_GOAL = 6'b001100;
	localparam logic [COLOUR_W-1:0] TILE_WALL = 6'b111111;
	localparam logic [COLOUR_W-1:0] TILE_KEY = 6'b111100;
	localparam logic [COLOUR_W-1:0] COLOUR_PLAYER = 6'b000011;

	// One-hot move requests
	localparam int unsigned DIR_W = 4;
	localparam logic [DIR_W-1:0] DIR_UP = 4'b1000;
	localparam logic [DIR_W-1:0] DIR_DOWN = 4'b0100;
	localparam logic [DIR_W-1:0] DIR_LEFT = 4'b0010;
	localparam logic [DIR_W-1:0] DIR_RIGHT = 4'b0001;

	localparam int unsigned LEVEL_COUNT = 2;
	localparam int unsigned LEVEL_W = 1;

	// Controller states
	localparam int unsigned STATE_W = 2;
	localparam logic [STATE_W-1:0] S_LOAD = 2'd0;
	localparam logic [STATE_W-1:0] S_DRAW = 2'd1;
	localparam logic [STATE_W-1:0] S_PLAY = 2'd2;
	localparam logic [STATE_W-1:0] S_KEY = 2'd3;

endpackage
